// ==== alu_simd.f ====
+incdir+hdl
hdl/alu_simd_pkg.sv
hdl/alu_cmd_if.sv
hdl/wb_cmd_front.sv
hdl/cmd_fifo.sv
hdl/simd_exec.sv
hdl/alu_simd_top.sv
tb/tb_clk_gen.sv
tb/tb_alu_simd.sv

// ==== hdl/alu_cmd_if.sv ====
// Valid/ready channel carrying one queued ALU command
`timescale 1ns/1ns
`include "alu_simd_cfg.svh"

interface alu_cmd_if
    import alu_simd_pkg::*;
();

    logic                   valid;
    logic                   ready;
    alu_op_e                op;
    lane_mode_e             mode;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;

    // Command source side
    modport push (
        output valid, op, mode, a, b,
        input  ready
    );

    // Command sink side
    modport pop (
        input  valid, op, mode, a, b,
        output ready
    );

endinterface

// ==== hdl/alu_simd_cfg.svh ====
// Width, queue depth and bus address macros
// for the packed-lane ALU
`ifndef ALU_SIMD_CFG_SVH
`define ALU_SIMD_CFG_SVH

// Operand and result width
`define ALU_DATA_W 64

// Opcode field width in the command word
`define ALU_OP_W 6

// Command queue entries, a power of two
`define ALU_FIFO_DEPTH 4

// Wishbone word address width
`define WB_ADR_W 2

`endif

// ==== hdl/alu_simd_pkg.sv ====
// Opcode, lane mode and register map types
// shared by the ALU RTL
`include "alu_simd_cfg.svh"

package alu_simd_pkg;

    // Opcodes keep the legacy encodings
    typedef enum logic [`ALU_OP_W-1:0] {
        OP_AND  = 6'd1,
        OP_OR   = 6'd2,
        OP_XOR  = 6'd3,
        OP_NOT  = 6'd4,
        OP_MOVE = 6'd5,
        OP_ADD  = 6'd6,
        OP_SUB  = 6'd7,
        OP_SLL  = 6'd10,
        OP_SRL  = 6'd11,
        OP_SRA  = 6'd12,
        OP_ROT  = 6'd13
    } alu_op_e;

    // Lane split of the 64-bit word
    typedef enum logic [1:0] {
        LANE_BYTE  = 2'd0,
        LANE_HALF  = 2'd1,
        LANE_WORD  = 2'd2,
        LANE_DWORD = 2'd3
    } lane_mode_e;

    // Wishbone word addresses
    typedef enum logic [1:0] {
        REG_A      = 2'd0,
        REG_B      = 2'd1,
        REG_CMD    = 2'd2,
        REG_RESULT = 2'd3
    } wb_reg_e;

endpackage

// ==== hdl/alu_simd_top.sv ====
// Top level of the packed-lane ALU with a Wishbone classic slave port
`timescale 1ns/1ns
`include "alu_simd_cfg.svh"

module alu_simd_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [`WB_ADR_W-1:0]   i_wb_adr,
    input  logic [`ALU_DATA_W-1:0] i_wb_dat,
    output logic                   o_wb_ack,
    output logic [`ALU_DATA_W-1:0] o_wb_dat
);

    logic                   res_valid;
    logic                   res_ready;
    logic [`ALU_DATA_W-1:0] res_data;

    // Front end to queue, queue to execution unit
    alu_cmd_if cmd_push ();
    alu_cmd_if cmd_pop ();

    wb_cmd_front wb_cmd_front_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_wb_dat    (o_wb_dat),
        .i_res_valid (res_valid),
        .i_res_data  (res_data),
        .o_res_ready (res_ready),
        .cmd         (cmd_push.push)
    );

    cmd_fifo cmd_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .wr      (cmd_push.pop),
        .rd      (cmd_pop.push)
    );

    simd_exec simd_exec_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .cmd         (cmd_pop.pop),
        .o_res_valid (res_valid),
        .o_res_data  (res_data),
        .i_res_ready (res_ready)
    );

endmodule

// ==== hdl/cmd_fifo.sv ====
// Show-ahead command FIFO between bus front end and execution unit
`timescale 1ns/1ns
`include "alu_simd_cfg.svh"

module cmd_fifo
    import alu_simd_pkg::*;
#(
    parameter int DEPTH = `ALU_FIFO_DEPTH
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    alu_cmd_if.pop wr,
    alu_cmd_if.push rd
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    alu_op_e                mem_op   [DEPTH];
    lane_mode_e             mem_mode [DEPTH];
    logic [`ALU_DATA_W-1:0] mem_a    [DEPTH];
    logic [`ALU_DATA_W-1:0] mem_b    [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign wr.ready = (count != CW'(DEPTH));
    assign rd.valid = (count != '0);
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    // Head entry is presented without waiting for a pop
    assign rd.op   = mem_op[rd_ptr];
    assign rd.mode = mem_mode[rd_ptr];
    assign rd.a    = mem_a[rd_ptr];
    assign rd.b    = mem_b[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem_op[wr_ptr]   <= wr.op;
            mem_mode[wr_ptr] <= wr.mode;
            mem_a[wr_ptr]    <= wr.a;
            mem_b[wr_ptr]    <= wr.b;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        count <= CW'(DEPTH)
    );

endmodule

// ==== hdl/simd_exec.sv ====
// Lane-wise SIMD ALU datapath with one result holding register
`timescale 1ns/1ns
`include "alu_simd_cfg.svh"

module simd_exec
    import alu_simd_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    alu_cmd_if.pop                 cmd,
    output logic                   o_res_valid,
    output logic [`ALU_DATA_W-1:0] o_res_data,
    input  logic                   i_res_ready
);

    localparam int DW = `ALU_DATA_W;

    // One candidate result per lane mode
    logic [3:0][DW-1:0] mode_res;
    logic [DW-1:0]      lane_sel;
    logic [DW-1:0]      alu_res;
    logic               accept;

    // Mode m uses lanes of 8 << m bits and 3 + m shift bits
    for (genvar m = 0; m < 4; m++) begin : g_mode
        localparam int LW = 8 << m;
        localparam int SW = 3 + m;

        for (genvar l = 0; l < DW / LW; l++) begin : g_lane
            logic [LW-1:0] a_l;
            logic [LW-1:0] b_l;
            logic [SW-1:0] amt;
            logic [LW-1:0] r_l;

            assign a_l = cmd.a[l*LW +: LW];
            assign b_l = cmd.b[l*LW +: LW];
            assign amt = b_l[SW-1:0];

            // Carries and shifted bits stay inside the lane
            always_comb begin
                case (cmd.op)
                    OP_ADD:  r_l = a_l + b_l;
                    OP_SUB:  r_l = a_l - b_l;
                    OP_SLL:  r_l = a_l << amt;
                    OP_SRL:  r_l = a_l >> amt;
                    OP_SRA:  r_l = $signed(a_l) >>> amt;
                    OP_ROT:  r_l = {a_l[LW/2-1:0], a_l[LW-1:LW/2]};
                    default: r_l = '0;
                endcase
            end

            assign mode_res[m][l*LW +: LW] = r_l;
        end
    end

    always_comb begin
        case (cmd.mode)
            LANE_BYTE:  lane_sel = mode_res[0];
            LANE_HALF:  lane_sel = mode_res[1];
            LANE_WORD:  lane_sel = mode_res[2];
            LANE_DWORD: lane_sel = mode_res[3];
            default:    lane_sel = '0;
        endcase
    end

    // Bitwise ops ignore the lane split
    always_comb begin
        case (cmd.op)
            OP_AND:  alu_res = cmd.a & cmd.b;
            OP_OR:   alu_res = cmd.a | cmd.b;
            OP_XOR:  alu_res = cmd.a ^ cmd.b;
            OP_NOT:  alu_res = ~cmd.a;
            OP_MOVE: alu_res = cmd.a;
            OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA, OP_ROT: begin
                alu_res = lane_sel;
            end
            // Unknown and retired opcodes
            default: alu_res = '0;
        endcase
    end

    // Take a new command when the holding register frees up this cycle
    assign cmd.ready = !o_res_valid || i_res_ready;
    assign accept    = cmd.valid && cmd.ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_res_valid <= 1'b0;
        end else if (accept) begin
            o_res_valid <= 1'b1;
        end else if (i_res_ready) begin
            o_res_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_res_data <= alu_res;
        end
    end

    // Unread result must not be overwritten
    a_res_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res_data))
    );

endmodule

// ==== hdl/wb_cmd_front.sv ====
// Wishbone classic slave with operand registers,
// command issue and result readback
`timescale 1ns/1ns
`include "alu_simd_cfg.svh"

module wb_cmd_front
    import alu_simd_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [`WB_ADR_W-1:0]   i_wb_adr,
    input  logic [`ALU_DATA_W-1:0] i_wb_dat,
    output logic                   o_wb_ack,
    output logic [`ALU_DATA_W-1:0] o_wb_dat,
    input  logic                   i_res_valid,
    input  logic [`ALU_DATA_W-1:0] i_res_data,
    output logic                   o_res_ready,
    alu_cmd_if.push                cmd
);

    wb_reg_e                sel;
    logic                   req;
    logic                   wr_req;
    logic                   rd_req;
    logic                   ack_d;
    logic [`ALU_DATA_W-1:0] reg_a;
    logic [`ALU_DATA_W-1:0] reg_b;

    // A request stays open until the one-cycle ack has gone out
    assign sel    = wb_reg_e'(i_wb_adr);
    assign req    = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr_req = req && i_wb_we;
    assign rd_req = req && !i_wb_we;

    // Command word carries the opcode in the low bits and the lane mode in 9:8
    assign cmd.valid = wr_req && (sel == REG_CMD);
    assign cmd.op    = alu_op_e'(i_wb_dat[`ALU_OP_W-1:0]);
    assign cmd.mode  = lane_mode_e'(i_wb_dat[9:8]);
    assign cmd.a     = reg_a;
    assign cmd.b     = reg_b;

    assign o_res_ready = rd_req && (sel == REG_RESULT);

    // CMD writes wait for queue room and RESULT reads for a result
    always_comb begin
        ack_d = req;
        if (cmd.valid) begin
            ack_d = cmd.ready;
        end
        if (o_res_ready) begin
            ack_d = i_res_valid;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= ack_d;
        end
    end

    // Operand registers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_a <= '0;
            reg_b <= '0;
        end else if (ack_d && i_wb_we) begin
            if (sel == REG_A) begin
                reg_a <= i_wb_dat;
            end
            if (sel == REG_B) begin
                reg_b <= i_wb_dat;
            end
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge i_clk) begin
        if (ack_d) begin
            if (i_wb_we) begin
                o_wb_dat <= '0;
            end else begin
                case (sel)
                    REG_A:      o_wb_dat <= reg_a;
                    REG_B:      o_wb_dat <= reg_b;
                    REG_RESULT: o_wb_dat <= i_res_data;
                    default:    o_wb_dat <= '0;
                endcase
            end
        end
    end

    a_ack_has_stb: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb)
    );

    // Each command is pushed once and acked in the following cycle
    a_push_acked: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (cmd.valid && cmd.ready) |=> (o_wb_ack && !cmd.valid)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile the alu_simd testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f alu_simd.f \
    --top-module tb_alu_simd &&
./obj_dir/Vtb_alu_simd | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

// ==== tb/tb_alu_simd.sv ====
// Testbench for the packed-lane ALU: Wishbone bus tasks,
// lane reference model and result checker
`timescale 1ns/1ns
`include "alu_simd_cfg.svh"

module tb_alu_simd
    import alu_simd_pkg::*;
();

    localparam int DW       = `ALU_DATA_W;
    localparam int ACK_WAIT = 20;
    localparam int NO_ACK   = 12;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [DW-1:0]        wb_dat_w;
    logic [DW-1:0]        wb_dat_r;
    logic                 wb_ack;

    // Expected and observed results, in issue order
    logic [DW-1:0] exp_q[$];
    logic [DW-1:0] got_q[$];
    logic [5:0]    op_q[$];
    logic [1:0]    mode_q[$];
    int            n_chk   = 0;
    int            err_cmp = 0;
    int            err_tb  = 0;

    tb_clk_gen clk_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    alu_simd_top alu_simd_top_i (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_ack (wb_ack),
        .o_wb_dat (wb_dat_r)
    );

    // Lane model: lane width 8 << mode, shift amount is B lane mod lane width
    function automatic logic [DW-1:0] alu_ref(input logic [5:0] op, input logic [1:0] mode,
                                              input logic [DW-1:0] a, input logic [DW-1:0] b);
        int            lw;
        int            amt;
        logic [DW-1:0] mask;
        logic [DW-1:0] la;
        logic [DW-1:0] lb;
        logic [DW-1:0] lr;
        logic [DW-1:0] res;
        lw   = 8 << mode;
        mask = {DW{1'b1}} >> (DW - lw);
        res  = '0;
        case (op)
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOT:  res = ~a;
            OP_MOVE: res = a;
            OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA, OP_ROT: begin
                for (int i = 0; i < DW / lw; i++) begin
                    la  = (a >> (i * lw)) & mask;
                    lb  = (b >> (i * lw)) & mask;
                    amt = int'(lb[5:0]) % lw;
                    case (op)
                        OP_ADD: lr = la + lb;
                        OP_SUB: lr = la - lb;
                        OP_SLL: lr = la << amt;
                        OP_SRL: lr = la >> amt;
                        OP_SRA: begin
                            lr = la >> amt;
                            // Negative lane refills from the top
                            if (la[lw-1]) begin
                                lr = lr | (mask & ~(mask >> amt));
                            end
                        end
                        OP_ROT:  lr = (la >> (lw / 2)) | (la << (lw / 2));
                        default: lr = '0;
                    endcase
                    res = res | ((lr & mask) << (i * lw));
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic logic [DW-1:0] cmd_word(input logic [5:0] op, input logic [1:0] mode);
        logic [DW-1:0] w;
        w      = '0;
        w[5:0] = op;
        w[9:8] = mode;
        return w;
    endfunction

    function automatic logic [DW-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // Compare every result read with its expected value
    always @(posedge clk) begin
        while (n_chk < got_q.size()) begin
            assert (n_chk < exp_q.size()) else begin
                $display("Result read with no command outstanding");
                err_cmp++;
            end
            if (n_chk < exp_q.size()) begin
                assert (got_q[n_chk] == exp_q[n_chk]) else begin
                    $display("[ERROR] o_wb_dat op %h mode %h: got %h expected %h",
                             op_q[n_chk], mode_q[n_chk], got_q[n_chk], exp_q[n_chk]);
                    err_cmp++;
                end
            end
            n_chk++;
        end
    end

    // Holds the strobe through the ack cycle, drops it afterwards or on timeout
    task automatic wait_ack(input int max_wait, output bit acked, output int cycles,
                            output logic [DW-1:0] rdat);
        acked  = 1'b0;
        cycles = 0;
        rdat   = '0;
        while (!acked && cycles < max_wait) begin
            @(posedge clk);
            #1;
            cycles++;
            acked = wb_ack;
            rdat  = wb_dat_r;
        end
        if (acked) begin
            @(posedge clk);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_reg_e adr, input logic [DW-1:0] dat, input int max_wait,
                            output bit acked, output int cycles);
        logic [DW-1:0] unused;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_ack(max_wait, acked, cycles, unused);
    endtask

    task automatic wb_read(input wb_reg_e adr, input int max_wait,
                           output bit acked, output int cycles, output logic [DW-1:0] rdat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(max_wait, acked, cycles, rdat);
    endtask

    task automatic check_acked(input bit acked, input string what);
        assert (acked) else begin
            $display("No ack for %s within %0d cycles", what, ACK_WAIT);
            err_tb++;
        end
    endtask

    task automatic check_latency(input bit acked, input int cycles, input string what);
        assert (acked && cycles == 1) else begin
            $display("%s acked after %0d cycles instead of one", what, cycles);
            err_tb++;
        end
    endtask

    task automatic issue_cmd(input logic [5:0] op, input logic [1:0] mode,
                             input logic [DW-1:0] a, input logic [DW-1:0] b);
        bit acked;
        int cycles;
        wb_write(REG_A, a, ACK_WAIT, acked, cycles);
        check_acked(acked, "operand A write");
        wb_write(REG_B, b, ACK_WAIT, acked, cycles);
        check_acked(acked, "operand B write");
        wb_write(REG_CMD, cmd_word(op, mode), ACK_WAIT, acked, cycles);
        check_acked(acked, "command write");
        if (acked) begin
            exp_q.push_back(alu_ref(op, mode, a, b));
            op_q.push_back(op);
            mode_q.push_back(mode);
        end
    endtask

    task automatic read_result();
        bit            acked;
        int            cycles;
        logic [DW-1:0] rd;
        wb_read(REG_RESULT, ACK_WAIT, acked, cycles, rd);
        check_acked(acked, "result read");
        if (acked) begin
            got_q.push_back(rd);
        end
    endtask

    task automatic run_op(input logic [5:0] op, input logic [1:0] mode,
                          input logic [DW-1:0] a, input logic [DW-1:0] b);
        issue_cmd(op, mode, a, b);
        read_result();
    endtask

    initial begin
        bit            acked;
        int            cycles;
        int            n;
        int            seed_dummy;
        logic [DW-1:0] rd;
        logic [DW-1:0] va;
        logic [DW-1:0] vb;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        seed_dummy = $urandom(95448);

        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(posedge clk);
            n++;
        end
        assert (rst_n === 1'b1) else begin
            $display("Reset was never released");
            err_tb++;
        end
        #1;

        // Operand registers read back, single-cycle ack
        va = rand64();
        vb = rand64();
        wb_write(REG_A, va, ACK_WAIT, acked, cycles);
        check_latency(acked, cycles, "REG_A write");
        wb_write(REG_B, vb, ACK_WAIT, acked, cycles);
        check_latency(acked, cycles, "REG_B write");
        wb_read(REG_A, ACK_WAIT, acked, cycles, rd);
        check_latency(acked, cycles, "REG_A read");
        assert (rd == va) else begin
            $display("[ERROR] o_wb_dat REG_A read %h expected %h", rd, va);
            err_tb++;
        end
        wb_read(REG_B, ACK_WAIT, acked, cycles, rd);
        check_latency(acked, cycles, "REG_B read");
        assert (rd == vb) else begin
            $display("[ERROR] o_wb_dat REG_B read %h expected %h", rd, vb);
            err_tb++;
        end

        // Every kept opcode with random operands in all lane modes
        for (int op = 1; op <= 13; op++) begin
            if (op != 8 && op != 9) begin
                for (int m = 0; m < 4; m++) begin
                    for (int k = 0; k < 4; k++) begin
                        va = rand64();
                        vb = rand64();
                        if (op == OP_SRA && k[0]) begin
                            va = va | 64'h8080_8080_8080_8080;
                        end
                        run_op(6'(op), 2'(m), va, vb);
                    end
                end
            end
        end

        // Saturated lanes, a carry or borrow would leak into the next lane
        for (int m = 0; m < 4; m++) begin
            vb = '0;
            for (int i = 0; i < DW; i += (8 << m)) begin
                vb[i] = 1'b1;
            end
            run_op(OP_ADD, 2'(m), '1, '1);
            run_op(OP_ADD, 2'(m), '1, vb);
            run_op(OP_SUB, 2'(m), '0, vb);
        end

        // Execution register plus a full queue take DEPTH + 1 commands
        for (int k = 0; k <= `ALU_FIFO_DEPTH; k++) begin
            issue_cmd(6'(6 + k % 2), 2'($urandom_range(3, 0)), rand64(), rand64());
        end
        wb_write(REG_CMD, cmd_word(OP_XOR, LANE_BYTE), NO_ACK, acked, cycles);
        assert (!acked) else begin
            $display("Command write was acked while the queue was full");
            err_tb++;
        end
        for (int k = 0; k <= `ALU_FIFO_DEPTH; k++) begin
            read_result();
        end
        wb_read(REG_RESULT, NO_ACK, acked, cycles, rd);
        assert (!acked) else begin
            $display("Result read was acked with no result pending");
            err_tb++;
        end

        // Dropped and unassigned opcodes
        run_op(6'd8, LANE_WORD, rand64(), rand64());
        run_op(6'd14, LANE_HALF, rand64(), rand64());
        run_op(6'd0, LANE_BYTE, rand64(), rand64());

        n = 0;
        while (n_chk < got_q.size() && n < 20) begin
            @(posedge clk);
            n++;
        end
        assert (n_chk == got_q.size() && got_q.size() == exp_q.size()) else begin
            $display("Issued %0d commands but checked %0d results", exp_q.size(), n_chk);
            err_tb++;
        end

        $display("Errors: bus and register %0d, result %0d, total %0d",
                 err_tb, err_cmp, err_tb + err_cmp);
        if (err_tb + err_cmp == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and active-low reset source
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RST_CYCLES  = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Release lands just after a rising edge, like the other inputs
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule
